//--- build.f
+incdir+testbench
design/pipe_pkg.sv
design/hazard_ctrl.sv
design/reg_file.sv
design/decode_stage.sv
design/exec_stage.sv
design/mem_stage.sv
design/pipe_top.sv
testbench/tb_pipe_top.sv

//--- design/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              stall,
    input  logic                              op_valid,
    input  logic [pipe_pkg::ALU_OP_W-1:0]     op_alu,
    input  logic [pipe_pkg::REG_AW-1:0]       op_rd,
    input  logic [pipe_pkg::REG_AW-1:0]       op_rs1,
    input  logic [pipe_pkg::REG_AW-1:0]       op_rs2,
    input  logic [pipe_pkg::DATA_WIDTH-1:0]   op_imm,
    input  logic                              op_use_imm,
    input  logic                              op_load,
    input  logic                              op_store,
    input  logic [pipe_pkg::DATA_WIDTH-1:0]   file_a,
    input  logic [pipe_pkg::DATA_WIDTH-1:0]   file_b,
    input  logic [pipe_pkg::DATA_WIDTH-1:0]   ex_result,
    input  logic [pipe_pkg::DATA_WIDTH-1:0]   wb_data,
    input  pipe_pkg::fwd_sel_t                fwd_a_sel,
    input  pipe_pkg::fwd_sel_t                fwd_b_sel,
    output logic                              id_valid,
    output logic [pipe_pkg::REG_AW-1:0]       id_rs1,
    output logic [pipe_pkg::REG_AW-1:0]       id_rs2,
    output logic                              id_rs2_used,
    output logic [pipe_pkg::ALU_OP_W-1:0]     id_alu,
    output logic [pipe_pkg::REG_AW-1:0]       id_rd,
    output logic                              id_load,
    output logic                              id_store,
    output logic                              id_reg_write,
    output logic [pipe_pkg::DATA_WIDTH-1:0]   opnd_a,
    output logic [pipe_pkg::DATA_WIDTH-1:0]   opnd_b,
    output logic [pipe_pkg::DATA_WIDTH-1:0]   store_data
);
    import pipe_pkg::*;

    logic [DATA_WIDTH-1:0] id_imm;
    logic                  id_use_imm;
    logic [DATA_WIDTH-1:0] fwd_a;
    logic [DATA_WIDTH-1:0] fwd_b;

    // Register holds its op while stalled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_valid     <= 1'b0;
            id_load      <= 1'b0;
            id_store     <= 1'b0;
            id_reg_write <= 1'b0;
            id_rs2_used  <= 1'b0;
            id_rs1       <= '0;
            id_rs2       <= '0;
            id_rd        <= '0;
        end else if (!stall) begin
            id_valid     <= op_valid;
            id_load      <= op_valid && op_load;
            id_store     <= op_valid && op_store;
            id_reg_write <= op_valid && !op_store && (op_rd != '0);
            id_rs2_used  <= op_store || (!op_use_imm && !op_load);  // Store data is rs2
            id_rs1       <= op_rs1;
            id_rs2       <= op_rs2;
            id_rd        <= op_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            id_alu     <= op_alu;
            id_imm     <= op_imm;
            id_use_imm <= op_use_imm;
        end
    end

    always_comb begin
        case (fwd_a_sel)
            FWD_EX:  fwd_a = ex_result;
            FWD_WB:  fwd_a = wb_data;
            default: fwd_a = file_a;
        endcase
        case (fwd_b_sel)
            FWD_EX:  fwd_b = ex_result;
            FWD_WB:  fwd_b = wb_data;
            default: fwd_b = file_b;
        endcase
    end

    assign opnd_a     = fwd_a;
    // Memory ops always take the offset
    assign opnd_b     = (id_use_imm || id_load || id_store) ? id_imm : fwd_b;
    assign store_data = fwd_b;

endmodule

//--- design/exec_stage.sv
`timescale 1ns/1ps

module exec_stage (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            ex_bubble,
    input  logic                            id_valid,
    input  logic [pipe_pkg::ALU_OP_W-1:0]   id_alu,
    input  logic [pipe_pkg::REG_AW-1:0]     id_rd,
    input  logic                            id_load,
    input  logic                            id_store,
    input  logic                            id_reg_write,
    input  logic [pipe_pkg::DATA_WIDTH-1:0] opnd_a,
    input  logic [pipe_pkg::DATA_WIDTH-1:0] opnd_b,
    input  logic [pipe_pkg::DATA_WIDTH-1:0] store_data,
    output logic                            ex_valid,
    output logic [pipe_pkg::DATA_WIDTH-1:0] ex_result,
    output logic [pipe_pkg::DATA_WIDTH-1:0] ex_store_data,
    output logic [pipe_pkg::REG_AW-1:0]     ex_rd,
    output logic                            ex_load,
    output logic                            ex_store,
    output logic                            ex_reg_write
);
    import pipe_pkg::*;

    localparam int SH_W = $clog2(DATA_WIDTH);

    logic [ALU_OP_W-1:0]   alu_sel;
    logic [DATA_WIDTH-1:0] alu_out;
    logic [SH_W-1:0]       shamt;

    assign alu_sel = (id_load || id_store) ? ALU_ADD : id_alu;  // Address = rs1 + imm
    assign shamt   = opnd_b[SH_W-1:0];

    always_comb begin
        case (alu_sel)
            ALU_ADD:    alu_out = opnd_a + opnd_b;
            ALU_SUB:    alu_out = opnd_a - opnd_b;
            ALU_AND:    alu_out = opnd_a & opnd_b;
            ALU_OR:     alu_out = opnd_a | opnd_b;
            ALU_XOR:    alu_out = opnd_a ^ opnd_b;
            ALU_NOR:    alu_out = ~(opnd_a | opnd_b);
            ALU_NAND:   alu_out = ~(opnd_a & opnd_b);
            ALU_SLL:    alu_out = opnd_a << shamt;
            ALU_SRL:    alu_out = opnd_a >> shamt;
            ALU_SRA:    alu_out = $signed(opnd_a) >>> shamt;
            ALU_SLT:    alu_out = {{(DATA_WIDTH-1){1'b0}}, $signed(opnd_a) < $signed(opnd_b)};
            ALU_SLTU:   alu_out = {{(DATA_WIDTH-1){1'b0}}, opnd_a < opnd_b};
            ALU_PASS_A: alu_out = opnd_a;
            ALU_PASS_B: alu_out = opnd_b;
            ALU_NOT_A:  alu_out = ~opnd_a;
            ALU_EQ:     alu_out = {{(DATA_WIDTH-1){1'b0}}, opnd_a == opnd_b};
            ALU_NE:     alu_out = {{(DATA_WIDTH-1){1'b0}}, opnd_a != opnd_b};
            ALU_INC_A:  alu_out = opnd_a + 1'b1;
            ALU_DEC_A:  alu_out = opnd_a - 1'b1;
            default:    alu_out = '0;  // Unused codes
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid     <= 1'b0;
            ex_load      <= 1'b0;
            ex_store     <= 1'b0;
            ex_reg_write <= 1'b0;
        end else begin
            ex_valid     <= id_valid && !ex_bubble;
            ex_load      <= id_load && !ex_bubble;
            ex_store     <= id_store && !ex_bubble;
            ex_reg_write <= id_reg_write && !ex_bubble;
        end
    end

    always_ff @(posedge clk) begin
        ex_result     <= alu_out;
        ex_store_data <= store_data;
        ex_rd         <= id_rd;
    end

endmodule

//--- design/hazard_ctrl.sv
`timescale 1ns/1ps

module hazard_ctrl (
    input  logic                        id_valid,
    input  logic [pipe_pkg::REG_AW-1:0] id_rs1,
    input  logic [pipe_pkg::REG_AW-1:0] id_rs2,
    input  logic                        id_rs2_used,
    input  logic                        ex_valid,
    input  logic                        ex_load,
    input  logic                        ex_reg_write,
    input  logic [pipe_pkg::REG_AW-1:0] ex_rd,
    input  logic                        wb_valid,
    input  logic [pipe_pkg::REG_AW-1:0] wb_rd,
    output logic                        stall,
    output logic                        ex_bubble,
    output pipe_pkg::fwd_sel_t          fwd_a_sel,
    output pipe_pkg::fwd_sel_t          fwd_b_sel
);
    import pipe_pkg::*;

    logic ex_fwd_ok;      // EX result already computed
    logic ex_ld_pending;  // EX holds a load, data not read yet
    logic load_use;

    // EX beats WB, WB beats the file
    function automatic fwd_sel_t pick_src(input logic ex_hit, input logic wb_hit);
        if (ex_hit)
            return FWD_EX;
        else if (wb_hit)
            return FWD_WB;
        else
            return FWD_FILE;
    endfunction

    assign ex_fwd_ok     = ex_valid && ex_reg_write && !ex_load;
    assign ex_ld_pending = ex_valid && ex_reg_write && ex_load;

    // rs1 is treated as always read
    assign load_use = id_valid && ex_ld_pending &&
                      ((ex_rd == id_rs1) || (id_rs2_used && (ex_rd == id_rs2)));

    assign stall     = load_use;
    assign ex_bubble = load_use;  // Load moves on, nothing enters EX

    // wb_valid already implies a register write to a nonzero rd
    assign fwd_a_sel = pick_src(ex_fwd_ok && (ex_rd == id_rs1), wb_valid && (wb_rd == id_rs1));
    assign fwd_b_sel = pick_src(ex_fwd_ok && (ex_rd == id_rs2), wb_valid && (wb_rd == id_rs2));

endmodule

//--- design/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            ex_valid,
    input  logic [pipe_pkg::DATA_WIDTH-1:0] ex_result,
    input  logic [pipe_pkg::DATA_WIDTH-1:0] ex_store_data,
    input  logic [pipe_pkg::REG_AW-1:0]     ex_rd,
    input  logic                            ex_load,
    input  logic                            ex_store,
    input  logic                            ex_reg_write,
    output logic                            wb_valid,
    output logic [pipe_pkg::REG_AW-1:0]     wb_rd,
    output logic [pipe_pkg::DATA_WIDTH-1:0] wb_data
);
    import pipe_pkg::*;

    logic [DATA_WIDTH-1:0] dmem [2**DMEM_AW];
    logic [DMEM_AW-1:0]    mem_idx;
    logic [DATA_WIDTH-1:0] mem_q;     // Synchronous read data
    logic [DATA_WIDTH-1:0] wb_alu;
    logic                  wb_load;

    assign mem_idx = ex_result[DMEM_AW-1:0];  // Word index, upper bits ignored

    // Data memory, one read and one write per edge
    always_ff @(posedge clk) begin
        if (ex_valid && ex_store) begin
            dmem[mem_idx] <= ex_store_data;
        end
        mem_q <= dmem[mem_idx];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            wb_load  <= 1'b0;
        end else begin
            wb_valid <= ex_valid && ex_reg_write;
            wb_load  <= ex_valid && ex_load;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd  <= ex_rd;
        wb_alu <= ex_result;
    end

    // Loads return the memory word
    assign wb_data = wb_load ? mem_q : wb_alu;

endmodule

//--- design/pipe_pkg.sv
package pipe_pkg;

    localparam int DATA_WIDTH = 32;  // Operand and result width
    localparam int REG_NUM    = 16;
    localparam int REG_AW     = 4;   // log2 of REG_NUM
    localparam int ALU_OP_W   = 5;
    localparam int DMEM_AW    = 6;   // 64 data words

    // ALU function codes, codes 19 to 31 produce zero
    typedef enum logic [ALU_OP_W-1:0] {
        ALU_ADD    = 5'd0,
        ALU_SUB    = 5'd1,
        ALU_AND    = 5'd2,
        ALU_OR     = 5'd3,
        ALU_XOR    = 5'd4,
        ALU_NOR    = 5'd5,
        ALU_NAND   = 5'd6,
        ALU_SLL    = 5'd7,   // Shift amount from B[4:0]
        ALU_SRL    = 5'd8,
        ALU_SRA    = 5'd9,
        ALU_SLT    = 5'd10,
        ALU_SLTU   = 5'd11,
        ALU_PASS_A = 5'd12,
        ALU_PASS_B = 5'd13,
        ALU_NOT_A  = 5'd14,
        ALU_EQ     = 5'd15,
        ALU_NE     = 5'd16,
        ALU_INC_A  = 5'd17,
        ALU_DEC_A  = 5'd18
    } alu_op_t;

    // Operand source for the decode muxes
    typedef enum logic [1:0] {
        FWD_FILE = 2'd0,  // Register file value
        FWD_EX   = 2'd1,  // ALU result in execute register
        FWD_WB   = 2'd2   // Writeback data
    } fwd_sel_t;

endpackage

//--- design/pipe_top.sv
`timescale 1ns/1ps

module pipe_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            op_valid,
    input  logic [pipe_pkg::ALU_OP_W-1:0]   op_alu,
    input  logic [pipe_pkg::REG_AW-1:0]     op_rd,
    input  logic [pipe_pkg::REG_AW-1:0]     op_rs1,
    input  logic [pipe_pkg::REG_AW-1:0]     op_rs2,
    input  logic [pipe_pkg::DATA_WIDTH-1:0] op_imm,
    input  logic                            op_use_imm,
    input  logic                            op_load,
    input  logic                            op_store,
    output logic                            stall,
    output logic                            wb_valid,
    output logic [pipe_pkg::REG_AW-1:0]     wb_rd,
    output logic [pipe_pkg::DATA_WIDTH-1:0] wb_data
);
    import pipe_pkg::*;

    // Decode stage outputs
    logic                  id_valid;
    logic [REG_AW-1:0]     id_rs1;
    logic [REG_AW-1:0]     id_rs2;
    logic                  id_rs2_used;
    logic [ALU_OP_W-1:0]   id_alu;
    logic [REG_AW-1:0]     id_rd;
    logic                  id_load;
    logic                  id_store;
    logic                  id_reg_write;
    logic [DATA_WIDTH-1:0] opnd_a;
    logic [DATA_WIDTH-1:0] opnd_b;
    logic [DATA_WIDTH-1:0] store_data;
    logic [DATA_WIDTH-1:0] file_a;
    logic [DATA_WIDTH-1:0] file_b;

    // Execute stage outputs
    logic                  ex_valid;
    logic [DATA_WIDTH-1:0] ex_result;
    logic [DATA_WIDTH-1:0] ex_store_data;
    logic [REG_AW-1:0]     ex_rd;
    logic                  ex_load;
    logic                  ex_store;
    logic                  ex_reg_write;

    logic                  ex_bubble;
    fwd_sel_t              fwd_a_sel;
    fwd_sel_t              fwd_b_sel;

    hazard_ctrl u_hazard (
        .id_valid(id_valid), .id_rs1(id_rs1), .id_rs2(id_rs2), .id_rs2_used(id_rs2_used),
        .ex_valid(ex_valid), .ex_load(ex_load), .ex_reg_write(ex_reg_write), .ex_rd(ex_rd),
        .wb_valid(wb_valid), .wb_rd(wb_rd),
        .stall(stall), .ex_bubble(ex_bubble), .fwd_a_sel(fwd_a_sel), .fwd_b_sel(fwd_b_sel)
    );

    // Written from writeback one edge after wb_valid shows
    reg_file u_regs (
        .clk(clk), .rst_n(rst_n),
        .wr_en(wb_valid), .wr_addr(wb_rd), .wr_data(wb_data),
        .rd_addr_a(id_rs1), .rd_addr_b(id_rs2),
        .rd_data_a(file_a), .rd_data_b(file_b)
    );

    decode_stage u_decode (
        .clk(clk), .rst_n(rst_n), .stall(stall),
        .op_valid(op_valid), .op_alu(op_alu), .op_rd(op_rd), .op_rs1(op_rs1),
        .op_rs2(op_rs2), .op_imm(op_imm), .op_use_imm(op_use_imm),
        .op_load(op_load), .op_store(op_store),
        .file_a(file_a), .file_b(file_b), .ex_result(ex_result), .wb_data(wb_data),
        .fwd_a_sel(fwd_a_sel), .fwd_b_sel(fwd_b_sel),
        .id_valid(id_valid), .id_rs1(id_rs1), .id_rs2(id_rs2), .id_rs2_used(id_rs2_used),
        .id_alu(id_alu), .id_rd(id_rd), .id_load(id_load), .id_store(id_store),
        .id_reg_write(id_reg_write),
        .opnd_a(opnd_a), .opnd_b(opnd_b), .store_data(store_data)
    );

    exec_stage u_exec (
        .clk(clk), .rst_n(rst_n), .ex_bubble(ex_bubble),
        .id_valid(id_valid), .id_alu(id_alu), .id_rd(id_rd), .id_load(id_load),
        .id_store(id_store), .id_reg_write(id_reg_write),
        .opnd_a(opnd_a), .opnd_b(opnd_b), .store_data(store_data),
        .ex_valid(ex_valid), .ex_result(ex_result), .ex_store_data(ex_store_data),
        .ex_rd(ex_rd), .ex_load(ex_load), .ex_store(ex_store), .ex_reg_write(ex_reg_write)
    );

    mem_stage u_mem (
        .clk(clk), .rst_n(rst_n),
        .ex_valid(ex_valid), .ex_result(ex_result), .ex_store_data(ex_store_data),
        .ex_rd(ex_rd), .ex_load(ex_load), .ex_store(ex_store), .ex_reg_write(ex_reg_write),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
    );

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            wr_en,
    input  logic [pipe_pkg::REG_AW-1:0]     wr_addr,
    input  logic [pipe_pkg::DATA_WIDTH-1:0] wr_data,
    input  logic [pipe_pkg::REG_AW-1:0]     rd_addr_a,
    input  logic [pipe_pkg::REG_AW-1:0]     rd_addr_b,
    output logic [pipe_pkg::DATA_WIDTH-1:0] rd_data_a,
    output logic [pipe_pkg::DATA_WIDTH-1:0] rd_data_b
);
    import pipe_pkg::*;

    logic [DATA_WIDTH-1:0] regs [REG_NUM];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin  // r0 stays zero
            regs[wr_addr] <= wr_data;
        end
    end

    // Asynchronous read ports
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile and run tb_pipe_top with Verilator, pass only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_pipe_top \
    -Mdir obj_dir -o tb_pipe_top -f build.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/tb_pipe_top > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "^TEST PASS$" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1

//--- testbench/pipe_model.svh
`ifndef PIPE_MODEL_SVH
`define PIPE_MODEL_SVH

// Architectural state, one update per accepted op
logic [DATA_WIDTH-1:0] arch_regs [REG_NUM];
logic [DATA_WIDTH-1:0] arch_mem  [2**DMEM_AW];

// Expected writebacks in program order
logic [REG_AW-1:0]     exp_rd_q[$];
logic [DATA_WIDTH-1:0] exp_data_q[$];

function automatic void model_reset();
    for (int i = 0; i < REG_NUM; i++) begin
        arch_regs[i] = '0;
    end
    exp_rd_q.delete();
    exp_data_q.delete();
endfunction

function automatic logic [DATA_WIDTH-1:0] alu_ref(
    input logic [ALU_OP_W-1:0]   code,
    input logic [DATA_WIDTH-1:0] a,
    input logic [DATA_WIDTH-1:0] b
);
    logic [DATA_WIDTH-1:0] r;
    case (code)
        ALU_ADD:    r = a + b;
        ALU_SUB:    r = a - b;
        ALU_AND:    r = a & b;
        ALU_OR:     r = a | b;
        ALU_XOR:    r = a ^ b;
        ALU_NOR:    r = ~a & ~b;
        ALU_NAND:   r = ~a | ~b;
        ALU_SLL:    r = a << b[4:0];
        ALU_SRL:    r = a >> b[4:0];
        ALU_SRA:    r = $signed(a) >>> b[4:0];  // Sign fill
        ALU_SLT:    r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        ALU_SLTU:   r = (a < b) ? 32'd1 : 32'd0;
        ALU_PASS_A: r = a;
        ALU_PASS_B: r = b;
        ALU_NOT_A:  r = ~a;
        ALU_EQ:     r = (a == b) ? 32'd1 : 32'd0;
        ALU_NE:     r = (a != b) ? 32'd1 : 32'd0;
        ALU_INC_A:  r = a + 32'd1;
        ALU_DEC_A:  r = a - 32'd1;
        default:    r = '0;
    endcase
    return r;
endfunction

// Executes one accepted op against the architectural state
function automatic void model_exec(
    input logic                  valid,
    input logic [ALU_OP_W-1:0]   alu,
    input logic [REG_AW-1:0]     rd,
    input logic [REG_AW-1:0]     rs1,
    input logic [REG_AW-1:0]     rs2,
    input logic [DATA_WIDTH-1:0] imm,
    input logic                  use_imm,
    input logic                  load,
    input logic                  store
);
    logic [DATA_WIDTH-1:0] a;
    logic [DATA_WIDTH-1:0] b;
    logic [DATA_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] result;
    if (valid) begin
        a    = arch_regs[rs1];
        b    = use_imm ? imm : arch_regs[rs2];
        addr = a + imm;  // Word index in the low bits
        if (store) begin
            arch_mem[addr[DMEM_AW-1:0]] = arch_regs[rs2];
        end else begin
            result = load ? arch_mem[addr[DMEM_AW-1:0]] : alu_ref(alu, a, b);
            if (rd != '0) begin
                arch_regs[rd] = result;
                exp_rd_q.push_back(rd);
                exp_data_q.push_back(result);
            end
        end
    end
endfunction

`endif

//--- testbench/tb_pipe_top.sv
`timescale 1ns/1ps

module tb_pipe_top;
    import pipe_pkg::*;

    localparam int N_OPS          = 400;
    localparam int TIMEOUT_CYCLES = 4 * N_OPS + 50;
    localparam int DRAIN_OPS      = 4;  // Enough idle slots to empty the pipe

    logic                  clk;
    logic                  rst_n;
    logic                  op_valid;
    logic [ALU_OP_W-1:0]   op_alu;
    logic [REG_AW-1:0]     op_rd;
    logic [REG_AW-1:0]     op_rs1;
    logic [REG_AW-1:0]     op_rs2;
    logic [DATA_WIDTH-1:0] op_imm;
    logic                  op_use_imm;
    logic                  op_load;
    logic                  op_store;
    logic                  stall;
    logic                  wb_valid;
    logic [REG_AW-1:0]     wb_rd;
    logic [DATA_WIDTH-1:0] wb_data;

    logic [31:0]           lcg_state;
    int                    cycle_cnt = 0;
    int                    op_count;
    logic                  stall_owed;  // Next presentation should see one stall
    logic                  prev_ld;     // Last accepted op was a register load
    logic [REG_AW-1:0]     prev_rd;

    `include "pipe_model.svh"

    pipe_top UUT (
        .clk(clk), .rst_n(rst_n),
        .op_valid(op_valid), .op_alu(op_alu), .op_rd(op_rd), .op_rs1(op_rs1),
        .op_rs2(op_rs2), .op_imm(op_imm), .op_use_imm(op_use_imm),
        .op_load(op_load), .op_store(op_store),
        .stall(stall), .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        return (lcg_next() >> 8) % n;  // Upper bits are less periodic
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("ERROR: %s = 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    // Presents one op, holds it through stall, then runs the model on acceptance
    task automatic issue_op(input logic valid, input logic [ALU_OP_W-1:0] alu,
                            input logic [REG_AW-1:0] rd, input logic [REG_AW-1:0] rs1,
                            input logic [REG_AW-1:0] rs2, input logic [DATA_WIDTH-1:0] imm,
                            input logic use_imm, input logic load, input logic store);
        int   stall_cycles;
        logic rs2_used;
        stall_cycles = 0;
        op_valid   <= valid;
        op_alu     <= alu;
        op_rd      <= rd;
        op_rs1     <= rs1;
        op_rs2     <= rs2;
        op_imm     <= imm;
        op_use_imm <= use_imm;
        op_load    <= load;
        op_store   <= store;
        @(negedge clk);
        while (stall === 1'b1) begin
            stall_cycles++;
            @(negedge clk);
        end
        @(posedge clk);  // Accepted on this edge
        check_value("stall_cycles", 32'(stall_cycles), {31'b0, stall_owed});
        model_exec(valid, alu, rd, rs1, rs2, imm, use_imm, load, store);
        if (store)
            rs2_used = 1'b1;  // Store data
        else if (load)
            rs2_used = 1'b0;  // Address takes the immediate
        else
            rs2_used = !use_imm;
        stall_owed = prev_ld && valid &&
                     ((prev_rd == rs1) || (rs2_used && (prev_rd == rs2)));
        prev_ld    = valid && load && (rd != '0);
        prev_rd    = rd;
        op_count++;
    endtask

    task automatic issue_random_op();
        int unsigned           kind;
        logic [REG_AW-1:0]     rd;
        logic [REG_AW-1:0]     rs1;
        logic [REG_AW-1:0]     rs2;
        logic [ALU_OP_W-1:0]   alu;
        logic [DATA_WIDTH-1:0] imm;
        logic                  use_imm;
        kind    = rand_below(16);
        rd      = REG_AW'(rand_below(8));  // Few registers give many hazards
        rs1     = REG_AW'(rand_below(8));
        rs2     = REG_AW'(rand_below(8));
        alu     = ALU_OP_W'(rand_below(32));
        imm     = lcg_next();
        use_imm = (rand_below(2) == 1);
        // Often read the register a load just targeted
        if (prev_ld && rand_below(2) == 0) begin
            if (rand_below(2) == 0)
                rs1 = prev_rd;
            else
                rs2 = prev_rd;
        end
        if (kind < 3)
            issue_op(1'b1, alu, rd, rs1, rs2, 32'(rand_below(64)), 1'b1, 1'b1, 1'b0);
        else if (kind < 5)
            issue_op(1'b1, alu, rd, rs1, rs2, 32'(rand_below(64)), 1'b0, 1'b0, 1'b1);
        else if (kind == 5)
            issue_op(1'b0, alu, rd, rs1, rs2, imm, use_imm, 1'b0, 1'b0);  // Idle slot
        else
            issue_op(1'b1, alu, rd, rs1, rs2, imm, use_imm, 1'b0, 1'b0);
    endtask

    // Writeback checker against the model queue
    always @(negedge clk) begin
        logic [REG_AW-1:0]     exp_rd;
        logic [DATA_WIDTH-1:0] exp_data;
        if (rst_n === 1'b1 && wb_valid === 1'b1) begin
            if (exp_rd_q.size() == 0) begin
                report_failure($sformatf("Unexpected writeback to r%0d with no op behind it",
                                         wb_rd));
            end else begin
                exp_rd   = exp_rd_q.pop_front();
                exp_data = exp_data_q.pop_front();
                check_value("wb_rd", {{(32-REG_AW){1'b0}}, wb_rd},
                            {{(32-REG_AW){1'b0}}, exp_rd});
                check_value("wb_data", wb_data, exp_data);
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("Timeout after %0d cycles, ops stopped completing",
                                     cycle_cnt));
        end
    end

    initial begin
        logic [REG_AW-1:0] r;
        rst_n      = 1'b0;
        op_valid   = 1'b0;
        op_alu     = '0;
        op_rd      = '0;
        op_rs1     = '0;
        op_rs2     = '0;
        op_imm     = '0;
        op_use_imm = 1'b0;
        op_load    = 1'b0;
        op_store   = 1'b0;
        lcg_state  = 32'h117e;
        op_count   = 0;
        stall_owed = 1'b0;
        prev_ld    = 1'b0;
        prev_rd    = '0;
        model_reset();

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("stall", {31'b0, stall}, 32'd0);
        check_value("wb_valid", {31'b0, wb_valid}, 32'd0);
        @(posedge clk);

        // Every register reads zero after reset, r0 lands in r1
        for (int k = 0; k < REG_NUM; k++) begin
            issue_op(1'b1, ALU_PASS_A, REG_AW'(k == 0 ? 1 : k), REG_AW'(k), REG_AW'(k),
                     '0, 1'b0, 1'b0, 1'b0);
        end

        // Fill data memory with store data forwarded from EX
        for (int i = 0; i < 2**DMEM_AW; i++) begin
            r = REG_AW'(1 + i % 7);
            issue_op(1'b1, ALU_ADD, r, '0, '0, 32'hc0de_0000 + i * 32'h0101_0101,
                     1'b1, 1'b0, 1'b0);
            issue_op(1'b1, ALU_ADD, '0, '0, r, 32'(i), 1'b0, 1'b0, 1'b1);
        end

        // All 32 codes with register and immediate B
        for (int c = 0; c < 32; c++) begin
            for (int m = 0; m < 2; m++) begin
                issue_op(1'b1, ALU_OP_W'(c), REG_AW'(1 + c % 7), REG_AW'(1 + (c + 2) % 7),
                         REG_AW'(1 + (c + 4) % 7), lcg_next(), 1'(m), 1'b0, 1'b0);
            end
        end

        // Back-to-back store and load at one index
        for (int j = 0; j < 8; j++) begin
            r = REG_AW'(1 + j % 7);
            issue_op(1'b1, ALU_ADD, '0, '0, r, 32'(j * 9), 1'b0, 1'b0, 1'b1);
            issue_op(1'b1, ALU_ADD, r, '0, '0, 32'(j * 9), 1'b1, 1'b1, 1'b0);
            issue_op(1'b1, ALU_ADD, '0, r, r, 32'(j), 1'b1, 1'b0, 1'b0);  // Stall, write r0
            issue_op(1'b1, ALU_PASS_A, REG_AW'(1 + (j + 3) % 7), '0, r, '0,
                     1'b0, 1'b0, 1'b0);  // r0 still reads zero
        end

        while (op_count < N_OPS) begin
            issue_random_op();
        end

        repeat (DRAIN_OPS) begin
            issue_op(1'b0, '0, '0, '0, '0, '0, 1'b0, 1'b0, 1'b0);
        end

        if (exp_rd_q.size() != 0) begin
            report_failure($sformatf("Missing writeback, %0d expected results never appeared",
                                     exp_rd_q.size()));
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule
